// File: src/psx_host_pkg.sv
// types assume a 27-bit byte address space and backup sectors of exactly 256 words
`default_nettype none

package psx_host_pkg;

	// ==================================================
	// memory map and framebuffer constants
	// ==================================================
	typedef logic [26:0] ram_addr_t;

	// image load addresses inside main memory
	localparam ram_addr_t bios_start = 27'd2097152;
	localparam ram_addr_t exe_start  = 27'd4194304;

	localparam logic [31:0] fb_base_addr = 32'h3000_0000;
	localparam logic [13:0] fb_stride    = 14'd2048;
	// 24bpp rgb
	localparam logic [4:0]  fb_fmt_24    = 5'b00101;
	// 16bpp 1555
	localparam logic [4:0]  fb_fmt_16    = 5'b01100;
	localparam logic [11:0] vram_view_w  = 12'd1024;
	localparam logic [11:0] vram_view_h  = 12'd512;

	// words per backup sector
	localparam int unsigned sector_words = 256;

	// ==================================================
	// bundles
	// ==================================================
	// host download bus, 16-bit halfwords
	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		ram_addr_t   addr;
		logic [15:0] dout;
		logic        wr;
	} ioctl_bus_t;

	// one 32-bit write into main memory
	typedef struct packed {
		ram_addr_t   addr;
		logic [31:0] data;
		logic [3:0]  be;
	} ram_wr_req_t;

	// backup access, addr is {sector, word}
	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] wdata;
		logic        rnw;
	} bk_req_t;

	typedef struct packed {
		logic       fb_enable;
		logic       color24;
		logic       vram_view;
		logic       is_pal;
		logic [1:0] aspect_sel;
		logic [1:0] scale;
	} host_opts_t;

	typedef struct packed {
		logic [11:0] width;
		logic [11:0] height;
		logic [9:0]  offset_x;
		logic [8:0]  offset_y;
	} disp_geom_t;

	typedef struct packed {
		logic        enable;
		logic [4:0]  format;
		logic [11:0] width;
		logic [11:0] height;
		logic [31:0] base;
		logic [13:0] stride;
		logic [11:0] arx;
		logic [11:0] ary;
	} fb_cfg_t;

endpackage

`default_nettype wire

// File: src/ram_write_port.sv
// the sender must hold wr low while ioctl_wait is high and keep download up until the last ack
`timescale 1ns/1ps
`default_nettype none

module ram_write_port (
	input  logic                      clk_1x,
	input  logic                      rst_n,
	input  psx_host_pkg::ioctl_bus_t  ioctl,
	output logic                      ioctl_wait,
	input  logic                      core_wr,
	input  psx_host_pkg::ram_wr_req_t core_wr_req,
	output logic                      mem_wr,
	output psx_host_pkg::ram_wr_req_t mem_wr_req,
	input  logic                      mem_wr_ack,
	output logic                      load_exe
);

	logic                    bios_dl;
	logic                    exe_dl;
	logic                    exe_dl_q;
	logic                    dl_active;
	logic                    dl_wr;
	psx_host_pkg::ram_addr_t dl_addr;
	logic [31:0]             dl_data;
	psx_host_pkg::ram_addr_t load_base;

	// ==================================================
	// download kind
	// ==================================================
	// index 0 bios, 1..254 exe, 255 ignored
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			bios_dl  <= 1'b0;
			exe_dl   <= 1'b0;
			exe_dl_q <= 1'b0;
			load_exe <= 1'b0;
		end else begin
			bios_dl  <= ioctl.download && (ioctl.index == 8'd0);
			exe_dl   <= ioctl.download && (ioctl.index != 8'd0) && (ioctl.index != 8'hff);
			exe_dl_q <= exe_dl;
			// falling edge of the exe flag, two cycles after download drops
			load_exe <= exe_dl_q && !exe_dl;
		end
	end

	assign dl_active = bios_dl | exe_dl;
	assign load_base = bios_dl ? psx_host_pkg::bios_start : psx_host_pkg::exe_start;

	// ==================================================
	// halfword packing
	// ==================================================
	always_ff @(posedge clk_1x) begin
		if (dl_active && ioctl.wr) begin
			if (!ioctl.addr[1]) begin
				// low half carries the word address
				dl_addr       <= ioctl.addr + load_base;
				dl_data[15:0] <= ioctl.dout;
			end else begin
				dl_data[31:16] <= ioctl.dout;
			end
		end
	end

	// write strobe and bus stall
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			dl_wr      <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			dl_wr <= 1'b0;
			if (!dl_active) begin
				ioctl_wait <= 1'b0;
			end else begin
				if (ioctl.wr && ioctl.addr[1]) begin
					dl_wr      <= 1'b1;
					ioctl_wait <= 1'b1;
				end
				// release one cycle after the ack
				if (mem_wr_ack)
					ioctl_wait <= 1'b0;
			end
		end
	end

	// channel owner, downloader wins during a download
	always_comb begin
		if (dl_active) begin
			mem_wr          = dl_wr;
			mem_wr_req.addr = dl_addr;
			mem_wr_req.data = dl_data;
			mem_wr_req.be   = 4'b1111;
		end else begin
			mem_wr     = core_wr;
			mem_wr_req = core_wr_req;
		end
	end

endmodule

`default_nettype wire

// File: src/backup_copier.sv
// bk_start must stay high for the whole sector and bk_load must not change while it is high
`timescale 1ns/1ps
`default_nettype none

module backup_copier (
	input  logic                  clk_1x,
	input  logic                  rst_n,
	input  logic                  bk_start,
	input  logic                  bk_load,
	input  logic [7:0]            bk_sector,
	output logic                  bk_done,
	output logic                  bk_req,
	output psx_host_pkg::bk_req_t bk_req_out,
	input  logic                  bk_ack,
	output logic [7:0]            buf_addr,
	output logic                  buf_wr,
	input  logic [15:0]           buf_rdata
);

	// issue a strobe, then wait for the ack
	typedef enum logic {st_issue, st_wait} state_t;

	state_t     state;
	logic [7:0] word_cnt;

	// ==================================================
	// sequencer
	// ==================================================
	always_ff @(posedge clk_1x) begin
		if (!rst_n || !bk_start) begin
			state    <= st_issue;
			word_cnt <= 8'd0;
			bk_done  <= 1'b0;
			bk_req   <= 1'b0;
		end else begin
			bk_req <= 1'b0;
			if (!bk_done) begin
				case (state)
					st_issue: begin
						bk_req <= 1'b1;
						state  <= st_wait;
					end
					st_wait: begin
						if (bk_ack) begin
							state <= st_issue;
							if (word_cnt == 8'(psx_host_pkg::sector_words - 1))
								bk_done <= 1'b1;
							else
								word_cnt <= word_cnt + 8'd1;
						end
					end
				endcase
			end
		end
	end

	// buffer read data lands one cycle after the counter moves
	assign buf_addr = word_cnt;
	// load direction writes the reply in the ack cycle
	assign buf_wr   = bk_load && bk_ack && (state == st_wait);

	assign bk_req_out.addr  = {bk_sector, word_cnt};
	assign bk_req_out.wdata = buf_rdata;
	assign bk_req_out.rnw   = bk_load;

endmodule

`default_nettype wire

// File: src/sector_buffer.sv
// same-cycle writes to one address from both ports leave the port b data in place
`timescale 1ns/1ps
`default_nettype none

module sector_buffer (
	input  logic        clk_1x,
	input  logic [7:0]  a_addr,
	input  logic [15:0] a_wdata,
	input  logic        a_wr,
	output logic [15:0] a_rdata,
	input  logic [7:0]  b_addr,
	input  logic [15:0] b_wdata,
	input  logic        b_wr,
	output logic [15:0] b_rdata
);

	logic [15:0] mem [psx_host_pkg::sector_words];
	logic [7:0]  a_addr_q;
	logic [7:0]  b_addr_q;

	always_ff @(posedge clk_1x) begin
		if (a_wr)
			mem[a_addr] <= a_wdata;
		if (b_wr)
			mem[b_addr] <= b_wdata;
		a_addr_q <= a_addr;
		b_addr_q <= b_addr;
	end

	// registered address, read returns new data
	assign a_rdata = mem[a_addr_q];
	assign b_rdata = mem[b_addr_q];

endmodule

`default_nettype wire

// File: src/video_config.sv
// is_pal and scale are not decoded here and offsets assume a 2048-byte VRAM line
`timescale 1ns/1ps
`default_nettype none

module video_config (
	input  logic                     clk_1x,
	input  logic                     rst_n,
	input  psx_host_pkg::host_opts_t opts,
	input  psx_host_pkg::disp_geom_t geom,
	output psx_host_pkg::fb_cfg_t    fb_cfg
);

	psx_host_pkg::fb_cfg_t cfg_next;
	logic [31:0]           view_offset;

	// ==================================================
	// decode
	// ==================================================
	// two bytes per pixel, 2048 bytes per line
	assign view_offset = (32'(geom.offset_x) << 1) + (32'(geom.offset_y) << 11);

	always_comb begin
		cfg_next.enable = opts.fb_enable;
		cfg_next.format = opts.color24 ? psx_host_pkg::fb_fmt_24 : psx_host_pkg::fb_fmt_16;
		cfg_next.stride = psx_host_pkg::fb_stride;

		// whole vram or the displayed window
		if (opts.vram_view) begin
			cfg_next.base   = psx_host_pkg::fb_base_addr;
			cfg_next.width  = psx_host_pkg::vram_view_w;
			cfg_next.height = psx_host_pkg::vram_view_h;
		end else begin
			cfg_next.base   = psx_host_pkg::fb_base_addr + view_offset;
			cfg_next.width  = geom.width;
			cfg_next.height = geom.height;
		end

		// original aspect
		if (opts.aspect_sel == 2'd0) begin
			cfg_next.arx = opts.vram_view ? 12'd2 : 12'd4;
			cfg_next.ary = opts.vram_view ? 12'd1 : 12'd3;
		end else begin
			// full screen or custom ratio slots
			cfg_next.arx = 12'(opts.aspect_sel) - 12'd1;
			cfg_next.ary = 12'd0;
		end
	end

	// output register
	always_ff @(posedge clk_1x) begin
		if (!rst_n)
			fb_cfg <= '0;
		else
			fb_cfg <= cfg_next;
	end

endmodule

`default_nettype wire

// File: src/psx_host_top.sv
// single clock domain and memory acks must be one-cycle pulses with one write outstanding
`timescale 1ns/1ps
`default_nettype none

module psx_host_top (
	input  logic                      clk_1x,
	input  logic                      rst_n,
	// download bus
	input  psx_host_pkg::ioctl_bus_t  ioctl,
	output logic                      ioctl_wait,
	output logic                      load_exe,
	// core write channel
	input  logic                      core_wr,
	input  psx_host_pkg::ram_wr_req_t core_wr_req,
	// memory write port
	output logic                      mem_wr,
	output psx_host_pkg::ram_wr_req_t mem_wr_req,
	input  logic                      mem_wr_ack,
	// backup port
	input  logic                      bk_start,
	input  logic                      bk_load,
	input  logic [7:0]                bk_sector,
	output logic                      bk_done,
	output logic                      bk_req,
	output psx_host_pkg::bk_req_t     bk_req_out,
	input  logic                      bk_ack,
	input  logic [15:0]               bk_rdata,
	// sd buffer host side
	input  logic [7:0]                sd_buff_addr,
	input  logic [15:0]               sd_buff_dout,
	input  logic                      sd_buff_wr,
	output logic [15:0]               sd_buff_din,
	// video
	input  psx_host_pkg::host_opts_t  opts,
	input  psx_host_pkg::disp_geom_t  geom,
	output psx_host_pkg::fb_cfg_t     fb_cfg
);

	// copier to buffer port a
	logic [7:0]  buf_addr;
	logic        buf_wr;
	logic [15:0] buf_rdata;

	// ==================================================
	// instances
	// ==================================================
	ram_write_port ram_write_port_i (
		.clk_1x      (clk_1x),
		.rst_n       (rst_n),
		.ioctl       (ioctl),
		.ioctl_wait  (ioctl_wait),
		.core_wr     (core_wr),
		.core_wr_req (core_wr_req),
		.mem_wr      (mem_wr),
		.mem_wr_req  (mem_wr_req),
		.mem_wr_ack  (mem_wr_ack),
		.load_exe    (load_exe)
	);

	backup_copier backup_copier_i (
		.clk_1x     (clk_1x),
		.rst_n      (rst_n),
		.bk_start   (bk_start),
		.bk_load    (bk_load),
		.bk_sector  (bk_sector),
		.bk_done    (bk_done),
		.bk_req     (bk_req),
		.bk_req_out (bk_req_out),
		.bk_ack     (bk_ack),
		.buf_addr   (buf_addr),
		.buf_wr     (buf_wr),
		.buf_rdata  (buf_rdata)
	);

	// load replies go straight into port a
	sector_buffer sector_buffer_i (
		.clk_1x  (clk_1x),
		.a_addr  (buf_addr),
		.a_wdata (bk_rdata),
		.a_wr    (buf_wr),
		.a_rdata (buf_rdata),
		.b_addr  (sd_buff_addr),
		.b_wdata (sd_buff_dout),
		.b_wr    (sd_buff_wr),
		.b_rdata (sd_buff_din)
	);

	video_config video_config_i (
		.clk_1x (clk_1x),
		.rst_n  (rst_n),
		.opts   (opts),
		.geom   (geom),
		.fb_cfg (fb_cfg)
	);

endmodule

`default_nettype wire

// File: verif/psx_host_props.sv
// bound into the DUT top and assumes the memory models never ack in the request cycle
`timescale 1ns/1ps
`default_nettype none

module psx_host_props (
	input logic clk_1x,
	input logic rst_n,
	input logic ioctl_wait,
	input logic mem_wr,
	input logic mem_wr_ack,
	input logic core_wr,
	input logic load_exe,
	input logic bk_start,
	input logic bk_req,
	input logic bk_ack
);

	int   assert_fails = 0;
	// a backup request is waiting for its ack
	logic bk_busy;

	always_ff @(posedge clk_1x) begin
		if (!rst_n || !bk_start)
			bk_busy <= 1'b0;
		else if (bk_req)
			bk_busy <= 1'b1;
		else if (bk_ack)
			bk_busy <= 1'b0;
	end

	// ==================================================
	// handshakes
	// ==================================================
	// downloader strobes only when the bus was not stalled
	mem_wr_issue: assert property (@(posedge clk_1x) disable iff (!rst_n)
		mem_wr |-> core_wr || !$past(ioctl_wait))
		else begin
			$error("mem_wr while a download write was pending");
			assert_fails++;
		end

	wait_hold: assert property (@(posedge clk_1x) disable iff (!rst_n)
		ioctl_wait && !mem_wr_ack |=> ioctl_wait)
		else begin
			$error("ioctl_wait dropped before mem_wr_ack");
			assert_fails++;
		end

	exe_pulse: assert property (@(posedge clk_1x) disable iff (!rst_n)
		load_exe |=> !load_exe)
		else begin
			$error("load_exe longer than one cycle");
			assert_fails++;
		end

	bk_single: assert property (@(posedge clk_1x) disable iff (!rst_n)
		bk_req |-> !bk_busy)
		else begin
			$error("bk_req raised again before bk_ack");
			assert_fails++;
		end

endmodule

`default_nettype wire

// File: verif/psx_host_tb.sv
// memory and backup models ack after 1 to 4 cycles and core writes are kept out of downloads
`timescale 1ns/1ps
`default_nettype none

module psx_host_tb;

	logic                      clk_1x;
	logic                      rst_n;
	psx_host_pkg::ioctl_bus_t  ioctl;
	logic                      ioctl_wait;
	logic                      load_exe;
	logic                      core_wr;
	psx_host_pkg::ram_wr_req_t core_wr_req;
	logic                      mem_wr;
	psx_host_pkg::ram_wr_req_t mem_wr_req;
	logic                      mem_wr_ack;
	logic                      bk_start;
	logic                      bk_load;
	logic [7:0]                bk_sector;
	logic                      bk_done;
	logic                      bk_req;
	psx_host_pkg::bk_req_t     bk_req_out;
	logic                      bk_ack;
	logic [15:0]               bk_rdata;
	logic [7:0]                sd_buff_addr;
	logic [15:0]               sd_buff_dout;
	logic                      sd_buff_wr;
	logic [15:0]               sd_buff_din;
	psx_host_pkg::host_opts_t  opts;
	psx_host_pkg::disp_geom_t  geom;
	psx_host_pkg::fb_cfg_t     fb_cfg;

	int                        errors;
	int                        checks;
	int                        tests;
	int                        cover_miss;
	logic                      cover_on;
	int                        exe_pulses;
	logic [31:0]               rng;
	int                        ack_left;
	int                        bk_left;
	logic [15:0]               bk_cur;
	psx_host_pkg::ram_wr_req_t wr_seen [$];
	psx_host_pkg::bk_req_t     bk_seen [$];

	psx_host_top dut_i (.*);

	// handshake properties on the DUT top
	bind psx_host_top psx_host_props props_i (
		.clk_1x     (clk_1x),
		.rst_n      (rst_n),
		.ioctl_wait (ioctl_wait),
		.mem_wr     (mem_wr),
		.mem_wr_ack (mem_wr_ack),
		.core_wr    (core_wr),
		.load_exe   (load_exe),
		.bk_start   (bk_start),
		.bk_req     (bk_req),
		.bk_ack     (bk_ack)
	);

	always #10 clk_1x = ~clk_1x;

	// ==================================================
	// helpers
	// ==================================================
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// image content that mixes every address bit
	function automatic logic [31:0] image_word(input psx_host_pkg::ram_addr_t a);
		return (32'(a) * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
	endfunction

	function automatic logic [15:0] save_word(input logic [7:0] a);
		return {a ^ 8'h3c, ~a} + 16'h1234;
	endfunction

	// backup memory content for {sector, word}
	function automatic logic [15:0] load_word(input logic [15:0] a);
		return {a[7:0], a[15:8]} ^ 16'ha5c3;
	endfunction

	task automatic next_cycle;
		@(posedge clk_1x);
		#2;
	endtask

	task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %0h expected %0h", name, got, exp);
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - errs_before);
	endtask

	task automatic wait_bus_ready(input string what);
		int n;
		n = 0;
		while (ioctl_wait && n < 200) begin
			next_cycle();
			n++;
		end
		if (ioctl_wait) begin
			errors++;
			$display("timeout: ioctl_wait never dropped during %s", what);
		end
	endtask

	task automatic wait_copy_done(input string what);
		int n;
		n = 0;
		while (!bk_done && n < 4000) begin
			next_cycle();
			n++;
		end
		if (!bk_done) begin
			errors++;
			$display("timeout: bk_done never rose during %s", what);
		end
	endtask

	// ==================================================
	// memory and backup models
	// ==================================================
	always @(posedge clk_1x) begin : mem_model
		logic ack_now;
		ack_now = 1'b0;
		// a write is outstanding from its strobe up to its ack
		if (cover_on && (mem_wr || ack_left > 0 || mem_wr_ack) && !ioctl_wait)
			cover_miss++;
		if (ack_left > 0) begin
			ack_left--;
			if (ack_left == 0)
				ack_now = 1'b1;
		end
		if (mem_wr) begin
			wr_seen.push_back(mem_wr_req);
			rng = xorshift(rng);
			ack_left = 1 + int'(rng[1:0]);
		end
		mem_wr_ack <= #2 ack_now;
	end

	// load_exe pulses since the last clear
	always @(posedge clk_1x) begin
		if (load_exe)
			exe_pulses++;
	end

	always @(posedge clk_1x) begin : bk_model
		logic ack_now;
		ack_now = 1'b0;
		if (bk_left > 0) begin
			bk_left--;
			if (bk_left == 0)
				ack_now = 1'b1;
		end
		if (bk_req) begin
			bk_seen.push_back(bk_req_out);
			bk_cur = bk_req_out.addr;
			rng = xorshift(rng);
			bk_left = 1 + int'(rng[1:0]);
		end
		// read data only valid with the ack
		bk_ack   <= #2 ack_now;
		bk_rdata <= #2 ack_now ? load_word(bk_cur) : 16'h0;
	end

	// ==================================================
	// download
	// ==================================================
	task automatic reset_test;
		int e;
		e = errors;
		check("outputs after reset", {mem_wr, ioctl_wait, load_exe, bk_req, bk_done}, 5'b0);
		finish_test("reset", e);
	endtask

	task automatic send_half(input psx_host_pkg::ram_addr_t a, input logic [15:0] d);
		wait_bus_ready("download");
		ioctl.addr = a;
		ioctl.dout = d;
		ioctl.wr   = 1'b1;
		next_cycle();
		ioctl.wr   = 1'b0;
	endtask

	task automatic download_image(input logic [7:0] idx, input int words,
			input psx_host_pkg::ram_addr_t base);
		psx_host_pkg::ram_wr_req_t exp;
		logic [31:0]               w;
		wr_seen.delete();
		ioctl.index    = idx;
		ioctl.download = 1'b1;
		// kind flag needs one cycle
		next_cycle();
		for (int i = 0; i < words; i++) begin
			w = image_word(27'(i * 4));
			send_half(27'(i * 4), w[15:0]);
			send_half(27'(i * 4 + 2), w[31:16]);
		end
		wait_bus_ready("last write");
		ioctl.download = 1'b0;
		check("write count", wr_seen.size(), words);
		for (int i = 0; i < words && i < wr_seen.size(); i++) begin
			exp.addr = base + 27'(i * 4);
			exp.data = image_word(27'(i * 4));
			exp.be   = 4'hf;
			check("mem_wr_req", wr_seen[i], exp);
		end
	endtask

	task automatic bios_download_test;
		int e;
		e = errors;
		download_image(8'h00, 8, psx_host_pkg::bios_start);
		finish_test("bios download", e);
	endtask

	task automatic exe_download_test;
		int e;
		int at;
		e          = errors;
		at         = 0;
		exe_pulses = 0;
		download_image(8'h01, 8, psx_host_pkg::exe_start);
		for (int k = 1; k <= 6; k++) begin
			next_cycle();
			if (load_exe)
				at = k;
		end
		check("load_exe pulses", exe_pulses, 1);
		check("load_exe delay", at, 2);
		finish_test("exe download", e);
	endtask

	task automatic backpressure_test;
		int e;
		e          = errors;
		cover_miss = 0;
		cover_on   = 1'b1;
		download_image(8'h07, 48, psx_host_pkg::exe_start);
		cover_on = 1'b0;
		check("uncovered write cycles", cover_miss, 0);
		// let the load_exe pulse pass
		repeat (4) next_cycle();
		finish_test("back-pressure", e);
	endtask

	task automatic core_passthrough_test;
		psx_host_pkg::ram_wr_req_t req;
		psx_host_pkg::ram_wr_req_t exp_q [$];
		int                        e;
		e = errors;
		wr_seen.delete();
		for (int i = 0; i < 8; i++) begin
			rng      = xorshift(rng);
			req.addr = rng[26:0];
			req.be   = rng[31:28];
			rng      = xorshift(rng);
			req.data = rng;
			exp_q.push_back(req);
			core_wr_req = req;
			core_wr     = 1'b1;
			next_cycle();
		end
		core_wr = 1'b0;
		next_cycle();
		check("core write count", wr_seen.size(), 8);
		for (int i = 0; i < 8 && i < wr_seen.size(); i++)
			check("mem_wr_req", wr_seen[i], exp_q[i]);
		finish_test("core pass-through", e);
	endtask

	// ==================================================
	// backup copy
	// ==================================================
	task automatic backup_test;
		psx_host_pkg::bk_req_t exp;
		int                    e;
		e = errors;
		// preload through the host port
		for (int i = 0; i < 256; i++) begin
			sd_buff_addr = 8'(i);
			sd_buff_dout = save_word(8'(i));
			sd_buff_wr   = 1'b1;
			next_cycle();
		end
		sd_buff_wr = 1'b0;

		// save sector 3c
		bk_seen.delete();
		bk_sector = 8'h3c;
		bk_load   = 1'b0;
		bk_start  = 1'b1;
		wait_copy_done("sector save");
		check("save request count", bk_seen.size(), 256);
		for (int i = 0; i < 256 && i < bk_seen.size(); i++) begin
			exp.addr  = {8'h3c, 8'(i)};
			exp.wdata = save_word(8'(i));
			exp.rnw   = 1'b0;
			check("bk_req_out", bk_seen[i], exp);
		end
		bk_start = 1'b0;
		next_cycle();
		check("bk_done after save", bk_done, 1'b0);

		// load sector 91
		bk_seen.delete();
		bk_sector = 8'h91;
		bk_load   = 1'b1;
		bk_start  = 1'b1;
		wait_copy_done("sector load");
		check("load request count", bk_seen.size(), 256);
		for (int i = 0; i < 256 && i < bk_seen.size(); i++) begin
			check("bk_req_out.addr", bk_seen[i].addr, {8'h91, 8'(i)});
			check("bk_req_out.rnw", bk_seen[i].rnw, 1'b1);
		end
		bk_start = 1'b0;
		bk_load  = 1'b0;
		next_cycle();
		check("bk_done after load", bk_done, 1'b0);

		// read back with one cycle from address to data
		for (int i = 0; i < 256; i++) begin
			sd_buff_addr = 8'(i);
			next_cycle();
			check("sd_buff_din", sd_buff_din, load_word({8'h91, 8'(i)}));
		end
		finish_test("backup save and load", e);
	endtask

	// ==================================================
	// video settings
	// ==================================================
	task automatic video_case(input psx_host_pkg::host_opts_t o, input psx_host_pkg::disp_geom_t g);
		psx_host_pkg::fb_cfg_t exp;
		exp.enable = o.fb_enable;
		exp.format = o.color24 ? 5'b00101 : 5'b01100;
		exp.stride = 14'd2048;
		if (o.vram_view) begin
			exp.base   = 32'h3000_0000;
			exp.width  = 12'd1024;
			exp.height = 12'd512;
		end else begin
			exp.base   = 32'h3000_0000 + 32'(g.offset_x) * 2 + 32'(g.offset_y) * 2048;
			exp.width  = g.width;
			exp.height = g.height;
		end
		if (o.aspect_sel == 2'd0) begin
			exp.arx = o.vram_view ? 12'd2 : 12'd4;
			exp.ary = o.vram_view ? 12'd1 : 12'd3;
		end else begin
			exp.arx = 12'(o.aspect_sel) - 12'd1;
			exp.ary = 12'd0;
		end
		opts = o;
		geom = g;
		next_cycle();
		check("fb_cfg", fb_cfg, exp);
	endtask

	task automatic video_test;
		int e;
		e = errors;
		video_case(psx_host_pkg::host_opts_t'{1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 2'd0},
			psx_host_pkg::disp_geom_t'{12'd640, 12'd480, 10'd16, 9'd8});
		video_case(psx_host_pkg::host_opts_t'{1'b1, 1'b1, 1'b1, 1'b0, 2'd0, 2'd1},
			psx_host_pkg::disp_geom_t'{12'd320, 12'd240, 10'd100, 9'd20});
		video_case(psx_host_pkg::host_opts_t'{1'b1, 1'b1, 1'b0, 1'b1, 2'd2, 2'd0},
			psx_host_pkg::disp_geom_t'{12'd368, 12'd256, 10'd1023, 9'd511});
		video_case(psx_host_pkg::host_opts_t'{1'b0, 1'b0, 1'b1, 1'b1, 2'd3, 2'd3},
			psx_host_pkg::disp_geom_t'{12'd512, 12'd240, 10'd5, 9'd300});
		finish_test("video config", e);
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		clk_1x       = 1'b0;
		rst_n        = 1'b0;
		ioctl        = '0;
		core_wr      = 1'b0;
		core_wr_req  = '0;
		mem_wr_ack   = 1'b0;
		bk_start     = 1'b0;
		bk_load      = 1'b0;
		bk_sector    = 8'h00;
		bk_ack       = 1'b0;
		bk_rdata     = 16'h0;
		sd_buff_addr = 8'h00;
		sd_buff_dout = 16'h0;
		sd_buff_wr   = 1'b0;
		opts         = '0;
		geom         = '0;
		errors       = 0;
		checks       = 0;
		tests        = 0;
		cover_miss   = 0;
		cover_on     = 1'b0;
		exe_pulses   = 0;
		rng          = 32'h8d96_6f80;
		ack_left     = 0;
		bk_left      = 0;
		bk_cur       = 16'h0;
		repeat (5) @(posedge clk_1x);
		#2;
		rst_n = 1'b1;

		reset_test();
		bios_download_test();
		exe_download_test();
		backpressure_test();
		core_passthrough_test();
		backup_test();
		video_test();

		errors = errors + dut_i.props_i.assert_fails;
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
src/psx_host_pkg.sv
src/ram_write_port.sv
src/backup_copier.sv
src/sector_buffer.sv
src/video_config.sv
src/psx_host_top.sv
verif/psx_host_props.sv
verif/psx_host_tb.sv

// File: Bender.yml
package:
  name: psx_host

sources:
  - src/psx_host_pkg.sv
  - src/ram_write_port.sv
  - src/backup_copier.sv
  - src/sector_buffer.sv
  - src/video_config.sv
  - src/psx_host_top.sv
  - target: simulation
    files:
      - verif/psx_host_props.sv
      - verif/psx_host_tb.sv
